// File: Makefile
# Verilator build and run of the user area testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_user_project
FILELIST ?= tb.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/event_counter.sv
// Free-running event counter
// Enable, bus load with byte enables and a compare register
// Per-bit override from the logic analyzer probes
// Compare match output for the interrupt
module event_counter #(
    parameter int BITS = 32
) (
    input  logic            wb_clk_i,
    input  logic            rst_n_i,
    reg_bus_if.responder    regs,
    input  logic [BITS-1:0] la_data_i,
    input  logic [BITS-1:0] la_oenb_i,
    output logic [BITS-1:0] count_o,
    output logic            match_o
);
    import user_pkg::*;

    logic [BITS-1:0]  count_q;
    logic [BITS-1:0]  cmp_q;
    logic             en_q;
    logic [REG_W-1:0] wmask;
    logic             wr_count;
    logic             wr_ctrl;
    logic             wr_cmp;
    logic [BITS-1:0]  count_wr;
    logic [BITS-1:0]  cmp_wr;
    logic [BITS-1:0]  count_base;
    logic [BITS-1:0]  count_d;

    // Register write decode
    assign wmask    = be_mask(regs.be);
    assign wr_count = regs.wr_o && (regs.ofs == OFS_COUNT);
    assign wr_ctrl  = regs.wr_o && (regs.ofs == OFS_CTRL);
    assign wr_cmp   = regs.wr_o && (regs.ofs == OFS_CMP);

    // Byte-merged write values, cut to the counter width
    assign count_wr = BITS'((REG_W'(count_q) & ~wmask) | (regs.wdata & wmask));
    assign cmp_wr   = BITS'((REG_W'(cmp_q) & ~wmask) | (regs.wdata & wmask));

    // Bus load beats counting, counting beats hold
    always_comb begin
        if (wr_count) begin
            count_base = count_wr;
        end else if (en_q) begin
            count_base = count_q + 1'b1;
        end else begin
            count_base = count_q;
        end
    end

    // Probe bits with oenb low take the analyzer value
    assign count_d = (count_base & la_oenb_i) | (la_data_i & ~la_oenb_i);

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            en_q    <= 1'b0;
            cmp_q   <= '1;
        end else begin
            count_q <= count_d;
            // Enable lives in bit 0 of the low byte
            if (wr_ctrl && regs.be[0]) begin
                en_q <= regs.wdata[0];
            end
            if (wr_cmp) begin
                cmp_q <= cmp_wr;
            end
        end
    end

    // Read data, only driven during a read strobe
    always_comb begin
        regs.rdata = '0;
        if (regs.rd_o) begin
            case (regs.ofs)
                OFS_COUNT: regs.rdata = REG_W'(count_q);
                OFS_CTRL:  regs.rdata = REG_W'(en_q);
                OFS_CMP:   regs.rdata = REG_W'(cmp_q);
                default:   regs.rdata = '0;
            endcase
        end
    end

    assign count_o = count_q;

    // Level match, high while count equals compare
    assign match_o = (count_q == cmp_q);

endmodule

// File: rtl/gpio_block.sv
// GPIO register block for the upper 32 pads
// Output and output-enable-bar registers with byte enables
// Two-flop input synchronizer and sticky rising-edge status
// Edge status is write-one-to-clear and drives an interrupt
module gpio_block (
    input  logic         wb_clk_i,
    input  logic         rst_n_i,
    reg_bus_if.responder regs,
    input  logic [31:0]  pad_in_i,
    output logic [31:0]  pad_out_o,
    output logic [31:0]  pad_oeb_o,
    output logic         edge_irq_o
);
    import user_pkg::*;

    logic [REG_W-1:0] wmask;
    logic [31:0]      out_q;
    logic [31:0]      oeb_q;
    logic [31:0]      sync1_q;
    logic [31:0]      sync2_q;
    logic [31:0]      in_d_q;
    logic [31:0]      edge_q;
    logic [31:0]      rise;
    logic [31:0]      clr;

    assign wmask = be_mask(regs.be);

    // Rising edge of the synchronized input
    assign rise = sync2_q & ~in_d_q;

    // Bits written as one in enabled bytes clear the status
    assign clr = (regs.wr_o && (regs.ofs == OFS_EDGE)) ? (regs.wdata & wmask) : '0;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            oeb_q   <= '1;
            sync1_q <= '0;
            sync2_q <= '0;
            in_d_q  <= '0;
            edge_q  <= '0;
        end else begin
            // Pad input synchronizer plus one stage for edge detect
            sync1_q <= pad_in_i;
            sync2_q <= sync1_q;
            in_d_q  <= sync2_q;
            // A new edge wins over a clear in the same cycle
            edge_q  <= (edge_q & ~clr) | rise;
            if (regs.wr_o && (regs.ofs == OFS_OUT)) begin
                out_q <= (out_q & ~wmask) | (regs.wdata & wmask);
            end
            if (regs.wr_o && (regs.ofs == OFS_OEB)) begin
                oeb_q <= (oeb_q & ~wmask) | (regs.wdata & wmask);
            end
        end
    end

    // Read data, IN is read-only
    always_comb begin
        regs.rdata = '0;
        if (regs.rd_o) begin
            case (regs.ofs)
                OFS_OUT:  regs.rdata = out_q;
                OFS_OEB:  regs.rdata = oeb_q;
                OFS_IN:   regs.rdata = sync2_q;
                OFS_EDGE: regs.rdata = edge_q;
                default:  regs.rdata = '0;
            endcase
        end
    end

    assign pad_out_o = out_q;
    assign pad_oeb_o = oeb_q;

    // Any pending edge raises the interrupt
    assign edge_irq_o = |edge_q;

endmodule

// File: rtl/reg_bus_if.sv
// Internal register bus between the Wishbone port and the blocks
// One-cycle write and read strobes, offset, data and byte enables
// Read data comes back from the responder in the same cycle
interface reg_bus_if;
    import user_pkg::*;

    // Strobes, valid for a single cycle
    logic             wr_o;
    logic             rd_o;

    // Request fields
    logic [1:0]       ofs;
    logic [REG_W-1:0] wdata;
    logic [3:0]       be;

    // Combinational read data from the block
    logic [REG_W-1:0] rdata;

    // Bus port side
    modport requester (
        output wr_o, rd_o, ofs, wdata, be,
        input  rdata
    );

    // Register block side
    modport responder (
        input  wr_o, rd_o, ofs, wdata, be,
        output rdata
    );

endinterface

// File: rtl/user_pkg.sv
// Shared definitions for the user area
// Pad count and the first pad owned by the GPIO block
// Register width, region codes and register offsets
// Byte-enable mask helper for register writes
package user_pkg;

    // Pads and data width
    localparam int MPRJ_IO_PADS = 38;
    localparam int GPIO_LSB     = 6;
    localparam int REG_W        = 32;

    // Address bits 7..4 select the region
    localparam logic [3:0] REGION_COUNTER = 4'd0;
    localparam logic [3:0] REGION_GPIO    = 4'd1;

    // Counter registers, address bits 3..2
    localparam logic [1:0] OFS_COUNT = 2'd0;
    localparam logic [1:0] OFS_CTRL  = 2'd1;
    localparam logic [1:0] OFS_CMP   = 2'd2;

    // GPIO registers, address bits 3..2
    localparam logic [1:0] OFS_OUT  = 2'd0;
    localparam logic [1:0] OFS_OEB  = 2'd1;
    localparam logic [1:0] OFS_IN   = 2'd2;
    localparam logic [1:0] OFS_EDGE = 2'd3;

    // Expand four byte enables into a bit mask
    function automatic logic [REG_W-1:0] be_mask(input logic [3:0] be);
        logic [REG_W-1:0] mask;
        mask = '0;
        for (int b = 0; b < 4; b++) begin
            mask[b*8 +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

endpackage

// File: rtl/user_project_wrapper.sv
// User area top level
// Wishbone slave port, event counter and GPIO block
// Logic analyzer probes feed and observe the counter
// Pads 37..6 belong to the GPIO block, pads 5..0 stay inputs
// Interrupts: counter match, GPIO edge, one spare
module user_project_wrapper #(
    parameter int BITS = 32
) (
    // Wishbone slave
    input  logic                             wb_clk_i,
    input  logic                             rst_n_i,
    input  logic                             wbs_stb_i,
    input  logic                             wbs_cyc_i,
    input  logic                             wbs_we_i,
    input  logic [3:0]                       wbs_sel_i,
    input  logic [31:0]                      wbs_dat_i,
    input  logic [31:0]                      wbs_adr_i,
    output logic                             wbs_ack_o,
    output logic [31:0]                      wbs_dat_o,

    // Logic analyzer
    input  logic [127:0]                     la_data_in,
    output logic [127:0]                     la_data_out,
    input  logic [127:0]                     la_oenb,

    // Pads
    input  logic [user_pkg::MPRJ_IO_PADS-1:0] io_in,
    output logic [user_pkg::MPRJ_IO_PADS-1:0] io_out,
    output logic [user_pkg::MPRJ_IO_PADS-1:0] io_oeb,

    // Interrupts
    output logic [2:0]                       user_irq
);
    import user_pkg::*;

    logic [BITS-1:0] cnt_value;
    logic            cnt_match;
    logic [31:0]     gpio_out;
    logic [31:0]     gpio_oeb;
    logic            edge_irq;

    // Register buses from the bus port to each block
    reg_bus_if cnt_bus ();
    reg_bus_if gpio_bus ();

    wb_slave_port u_wb_slave_port (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .stb_i    (wbs_stb_i),
        .cyc_i    (wbs_cyc_i),
        .we_i     (wbs_we_i),
        .sel_i    (wbs_sel_i),
        .dat_i    (wbs_dat_i),
        .adr_i    (wbs_adr_i),
        .ack_o    (wbs_ack_o),
        .dat_o    (wbs_dat_o),
        .cnt_bus  (cnt_bus.requester),
        .gpio_bus (gpio_bus.requester)
    );

    // Counter sees only the low probe bits
    event_counter #(
        .BITS (BITS)
    ) u_event_counter (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .regs      (cnt_bus.responder),
        .la_data_i (la_data_in[BITS-1:0]),
        .la_oenb_i (la_oenb[BITS-1:0]),
        .count_o   (cnt_value),
        .match_o   (cnt_match)
    );

    gpio_block u_gpio_block (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .regs       (gpio_bus.responder),
        .pad_in_i   (io_in[MPRJ_IO_PADS-1:GPIO_LSB]),
        .pad_out_o  (gpio_out),
        .pad_oeb_o  (gpio_oeb),
        .edge_irq_o (edge_irq)
    );

    // Management-owned pads held as inputs driving zero
    assign io_out = {gpio_out, {GPIO_LSB{1'b0}}};
    assign io_oeb = {gpio_oeb, {GPIO_LSB{1'b1}}};

    // Count visible on the analyzer, zero-extended
    assign la_data_out = 128'(cnt_value);

    // Spare interrupt tied low
    assign user_irq = {1'b0, edge_irq, cnt_match};

endmodule

// File: rtl/wb_slave_port.sv
// Wishbone slave port for the user area
// Detects new bus cycles and decodes region and offset
// Issues one strobe to the counter or GPIO register bus
// Registers the acknowledge and the read data
module wb_slave_port (
    input  logic                      wb_clk_i,
    input  logic                      rst_n_i,
    input  logic                      stb_i,
    input  logic                      cyc_i,
    input  logic                      we_i,
    input  logic [3:0]                sel_i,
    input  logic [user_pkg::REG_W-1:0] dat_i,
    input  logic [31:0]               adr_i,
    output logic                      ack_o,
    output logic [user_pkg::REG_W-1:0] dat_o,
    reg_bus_if.requester              cnt_bus,
    reg_bus_if.requester              gpio_bus
);
    import user_pkg::*;

    logic             req;
    logic             new_req;
    logic [3:0]       region;
    logic             hit_cnt;
    logic             hit_gpio;
    logic [REG_W-1:0] rd_mux;
    logic             ack_q;
    logic [REG_W-1:0] dat_q;

    // Cycle present on the bus
    assign req = cyc_i && stb_i;

    // A request still held during its acknowledge is not taken twice
    assign new_req = req && !ack_q;

    // Region decode; upper address bits are not checked
    assign region   = adr_i[7:4];
    assign hit_cnt  = (region == REGION_COUNTER);
    assign hit_gpio = (region == REGION_GPIO);

    // Request fields are shared, only the strobes are steered
    assign cnt_bus.ofs    = adr_i[3:2];
    assign cnt_bus.wdata  = dat_i;
    assign cnt_bus.be     = sel_i;
    assign gpio_bus.ofs   = adr_i[3:2];
    assign gpio_bus.wdata = dat_i;
    assign gpio_bus.be    = sel_i;

    // Strobes fire in the cycle that registers the acknowledge
    assign cnt_bus.wr_o  = new_req && we_i && hit_cnt;
    assign cnt_bus.rd_o  = new_req && !we_i && hit_cnt;
    assign gpio_bus.wr_o = new_req && we_i && hit_gpio;
    assign gpio_bus.rd_o = new_req && !we_i && hit_gpio;

    // Read data select, unmapped regions give zero
    always_comb begin
        if (hit_cnt) begin
            rd_mux = cnt_bus.rdata;
        end else if (hit_gpio) begin
            rd_mux = gpio_bus.rdata;
        end else begin
            rd_mux = '0;
        end
    end

    // Acknowledge one cycle after the request is first seen
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= new_req;
        end
    end

    // Capture read data with the acknowledge
    always_ff @(posedge wb_clk_i) begin
        if (new_req && !we_i) begin
            dat_q <= rd_mux;
        end
    end

    assign ack_o = ack_q;
    assign dat_o = dat_q;

endmodule

// File: tb.f
rtl/user_pkg.sv
rtl/reg_bus_if.sv
rtl/wb_slave_port.sv
rtl/event_counter.sv
rtl/gpio_block.sv
rtl/user_project_wrapper.sv
tests/tb_user_project.sv

// File: tests/tb_user_project.sv
// Testbench for the user area top level
// Clock, reset, Wishbone write and read tasks
// Cycle-level reference model of the counter and GPIO registers
// Concurrent assertions on the acknowledge, immediate checks on data
module tb_user_project;
    timeunit 1ns;
    timeprecision 1ps;
    import user_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int TRANSACTIONS = 36;
    localparam int LIMIT_CYCLES = TRANSACTIONS * 20 + 1000;

    logic         clk;
    logic         rst_n_i;
    logic         wbs_stb_i;
    logic         wbs_cyc_i;
    logic         wbs_we_i;
    logic [3:0]   wbs_sel_i;
    logic [31:0]  wbs_dat_i;
    logic [31:0]  wbs_adr_i;
    logic         wbs_ack_o;
    logic [31:0]  wbs_dat_o;
    logic [127:0] la_data_in;
    logic [127:0] la_data_out;
    logic [127:0] la_oenb;
    logic [37:0]  io_in;
    logic [37:0]  io_out;
    logic [37:0]  io_oeb;
    logic [2:0]   user_irq;
    logic         req;
    int           errors = 0;
    int           checks = 0;

    // Reference model state
    logic         exp_ack;
    logic         exp_en;
    logic [31:0]  exp_count;
    logic [31:0]  exp_cmp;
    logic [31:0]  exp_out;
    logic [31:0]  exp_oeb;
    logic [31:0]  exp_sync1;
    logic [31:0]  exp_sync2;
    logic [31:0]  exp_prev;
    logic [31:0]  exp_edge;
    logic [31:0]  exp_rdata;

    user_project_wrapper #(.BITS(32)) dut0 (
        .wb_clk_i (clk),        .rst_n_i (rst_n_i),
        .wbs_stb_i (wbs_stb_i), .wbs_cyc_i (wbs_cyc_i), .wbs_we_i (wbs_we_i),
        .wbs_sel_i (wbs_sel_i), .wbs_dat_i (wbs_dat_i), .wbs_adr_i (wbs_adr_i),
        .wbs_ack_o (wbs_ack_o), .wbs_dat_o (wbs_dat_o),
        .la_data_in (la_data_in), .la_data_out (la_data_out), .la_oenb (la_oenb),
        .io_in (io_in), .io_out (io_out), .io_oeb (io_oeb), .user_irq (user_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign req = wbs_cyc_i && wbs_stb_i;

    // Handshake timing at the ports
    assert property (@(posedge clk) disable iff (!rst_n_i) (req && !wbs_ack_o) |=> wbs_ack_o)
        else begin
            errors++;
            $display("Acknowledge did not follow a new request at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (!rst_n_i) wbs_ack_o |=> !wbs_ack_o)
        else begin
            errors++;
            $display("Acknowledge held longer than one cycle at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (!rst_n_i) !req |=> !wbs_ack_o)
        else begin
            errors++;
            $display("Acknowledge without a request at %0t", $time);
        end

    function automatic logic [31:0] byte_mask(input logic [3:0] sel);
        logic [31:0] mask;
        mask = '0;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) mask[b*8 +: 8] = 8'hff;
        end
        return mask;
    endfunction

    // Old value with the enabled bytes replaced
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] sel);
        return (old & ~byte_mask(sel)) | (data & byte_mask(sel));
    endfunction

    function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [1:0] ofs);
        return {24'h0, region, ofs, 2'b00};
    endfunction

    // Register contents as the model sees them before the current edge
    function automatic logic [31:0] expected_read(input logic [31:0] adr);
        if (adr[7:4] == REGION_COUNTER) begin
            case (adr[3:2])
                OFS_COUNT: return exp_count;
                OFS_CTRL:  return {31'b0, exp_en};
                OFS_CMP:   return exp_cmp;
                default:   return '0;
            endcase
        end else if (adr[7:4] == REGION_GPIO) begin
            case (adr[3:2])
                OFS_OUT: return exp_out;
                OFS_OEB: return exp_oeb;
                OFS_IN:  return exp_sync2;
                default: return exp_edge;
            endcase
        end
        return '0;
    endfunction

    // Model steps on each rising edge from the inputs it sees there
    always @(posedge clk) begin : model_step
        logic        take;
        logic [31:0] next_count;
        logic [31:0] clr;
        take = req && !exp_ack;
        next_count = exp_en ? exp_count + 32'd1 : exp_count;
        clr = '0;
        if (!rst_n_i) begin
            exp_ack   <= 1'b0;
            exp_en    <= 1'b0;
            exp_count <= '0;
            exp_cmp   <= '1;
            exp_out   <= '0;
            exp_oeb   <= '1;
            exp_sync1 <= '0;
            exp_sync2 <= '0;
            exp_prev  <= '0;
            exp_edge  <= '0;
        end else begin
            exp_ack <= take;
            if (take && !wbs_we_i) begin
                exp_rdata <= expected_read(wbs_adr_i);
            end
            if (take && wbs_we_i && wbs_adr_i[7:4] == REGION_COUNTER) begin
                case (wbs_adr_i[3:2])
                    OFS_COUNT: next_count = merge_bytes(exp_count, wbs_dat_i, wbs_sel_i);
                    OFS_CTRL: begin
                        if (wbs_sel_i[0]) exp_en <= wbs_dat_i[0];
                    end
                    OFS_CMP: exp_cmp <= merge_bytes(exp_cmp, wbs_dat_i, wbs_sel_i);
                    default: ;
                endcase
            end
            if (take && wbs_we_i && wbs_adr_i[7:4] == REGION_GPIO) begin
                case (wbs_adr_i[3:2])
                    OFS_OUT:  exp_out <= merge_bytes(exp_out, wbs_dat_i, wbs_sel_i);
                    OFS_OEB:  exp_oeb <= merge_bytes(exp_oeb, wbs_dat_i, wbs_sel_i);
                    OFS_EDGE: clr = wbs_dat_i & byte_mask(wbs_sel_i);
                    default: ;
                endcase
            end
            // Probe bits with oenb low follow the analyzer
            exp_count <= (next_count & la_oenb[31:0]) | (la_data_in[31:0] & ~la_oenb[31:0]);
            exp_sync1 <= io_in[MPRJ_IO_PADS-1:GPIO_LSB];
            exp_sync2 <= exp_sync1;
            exp_prev  <= exp_sync2;
            // New edge beats a clear
            exp_edge  <= (exp_edge & ~clr) | (exp_sync2 & ~exp_prev);
        end
    end

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        assert (act === exp)
            else begin
                errors++;
                $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            end
    endtask

    // Outputs compared with the model mid-cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            check_value("la_data_out", 128'(exp_count), la_data_out);
            check_value("user_irq", 128'({1'b0, |exp_edge, exp_count == exp_cmp}), 128'(user_irq));
            check_value("io_out", 128'({exp_out, 6'b0}), 128'(io_out));
            check_value("io_oeb", 128'({exp_oeb, 6'h3f}), 128'(io_oeb));
        end
    end

    task automatic wait_ack();
        do @(negedge clk); while (!wbs_ack_o);
    endtask

    task automatic release_bus();
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] data, input logic [3:0] sel);
        wbs_adr_i = adr;
        wbs_dat_i = data;
        wbs_sel_i = sel;
        wbs_we_i  = 1'b1;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wait_ack();
        release_bus();
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
        wbs_adr_i = adr;
        wbs_sel_i = 4'hf;
        wbs_we_i  = 1'b0;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wait_ack();
        check_value("wbs_dat_o", 128'(exp_rdata), 128'(wbs_dat_o));
        data = wbs_dat_o;
        release_bus();
    endtask

    initial begin : stimulus
        logic [31:0] d;
        logic [31:0] c1;
        logic [31:0] mask;
        logic [1:0]  ofs;
        int          hits;
        void'($urandom(32'had2f039d));
        rst_n_i = 1'b0;
        release_bus();
        wbs_sel_i  = '0;
        wbs_dat_i  = '0;
        wbs_adr_i  = '0;
        la_data_in = '0;
        la_oenb    = '1;
        io_in      = '0;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;

        // Reset values and unmapped regions
        check_value("wbs_ack_o", 128'(0), 128'(wbs_ack_o));
        check_value("user_irq", 128'(0), 128'(user_irq));
        check_value("io_oeb", 128'({38{1'b1}}), 128'(io_oeb));
        check_value("la_data_out", 128'(0), la_data_out);
        wb_write(32'habcd_0030, 32'hdead_beef, 4'hf);
        wb_read(32'habcd_0030, d);
        check_value("unmapped read", 128'(0), 128'(d));

        // Counter registers with random byte enables, each offset in turn
        for (int i = 0; i < 8; i++) begin
            ofs = 2'(i % 3);
            wb_write(reg_addr(REGION_COUNTER, ofs), $urandom, 4'($urandom));
            wb_read(reg_addr(REGION_COUNTER, ofs), d);
        end
        wb_write(reg_addr(REGION_COUNTER, OFS_CTRL), 32'h1, 4'hf);
        wb_read(reg_addr(REGION_COUNTER, OFS_COUNT), c1);
        repeat (7) @(negedge clk);
        wb_read(reg_addr(REGION_COUNTER, OFS_COUNT), d);
        check_value("count step", 128'(8), 128'(d - c1));

        // Analyzer override with random masks
        repeat (20) begin
            la_oenb    = {$urandom, $urandom, $urandom, $urandom};
            la_data_in = {$urandom, $urandom, $urandom, $urandom};
            @(negedge clk);
        end
        la_oenb = '1;

        // Compare match lasts one cycle
        wb_write(reg_addr(REGION_COUNTER, OFS_CTRL), 32'h0, 4'hf);
        wb_write(reg_addr(REGION_COUNTER, OFS_CMP), 32'h100, 4'hf);
        wb_write(reg_addr(REGION_COUNTER, OFS_COUNT), 32'hfc, 4'hf);
        wb_write(reg_addr(REGION_COUNTER, OFS_CTRL), 32'h1, 4'hf);
        hits = 0;
        repeat (12) begin
            @(negedge clk);
            if (user_irq[0]) hits++;
        end
        check_value("match cycles", 128'(1), 128'(hits));

        // GPIO outputs and synchronized inputs
        wb_write(reg_addr(REGION_GPIO, OFS_OUT), $urandom, 4'hf);
        wb_write(reg_addr(REGION_GPIO, OFS_OEB), $urandom, 4'hf);
        wb_write(reg_addr(REGION_GPIO, OFS_OUT), $urandom, 4'b0101);
        wb_read(reg_addr(REGION_GPIO, OFS_OEB), d);
        io_in = {32'($urandom), 6'($urandom)};
        repeat (2) @(negedge clk);
        wb_read(reg_addr(REGION_GPIO, OFS_IN), d);
        check_value("pad inputs", 128'(io_in[37:6]), 128'(d));

        // Edge status, rising only, write-one-to-clear
        io_in[37:6] = '0;
        repeat (4) @(negedge clk);
        wb_write(reg_addr(REGION_GPIO, OFS_EDGE), 32'hffff_ffff, 4'hf);
        check_value("edge irq", 128'(0), 128'(user_irq[1]));
        mask = $urandom | 32'h1;
        io_in[37:6] = mask;
        repeat (5) @(negedge clk);
        wb_read(reg_addr(REGION_GPIO, OFS_EDGE), d);
        check_value("edge status", 128'(mask), 128'(d));
        wb_write(reg_addr(REGION_GPIO, OFS_EDGE), mask & 32'h0000_ffff, 4'hf);
        wb_read(reg_addr(REGION_GPIO, OFS_EDGE), d);
        check_value("edge partial clear", 128'(mask & 32'hffff_0000), 128'(d));
        wb_write(reg_addr(REGION_GPIO, OFS_EDGE), mask, 4'hf);
        check_value("edge irq", 128'(0), 128'(user_irq[1]));
        // Falling pads leave the cleared status empty
        io_in[37:6] = '0;
        repeat (5) @(negedge clk);
        wb_read(reg_addr(REGION_GPIO, OFS_EDGE), d);
        check_value("edge after fall", 128'(0), 128'(d));
        repeat (3) @(negedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the transaction count
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule
